// ==== testbench/cart_stimulus.txt ====
# B addr data | S index | C addr data ack_delay (0 = random) | E end of download
# X flash_1m sram_quirk remap_quirk cart_type max_pak_addr (all hex)
B 0000 BEEF
B 0002 DEAD
B 3FFC 5678
B 3FFE 1234
E
S 41
C 00A0 4F52 1
C 00A2 4B43 0
C 00A4 2059 3
C 00A6 4F42 0
C 00A8 4958 2
C 00AA 474E 0
C 00AC 4C46 1
C 00AE 5341 4
C 00B0 3148 0
C 00B2 5F4D 1
C 00B4 0056 0
E
X 1 1 0 1 2D
S 82
C 00A0 4150 0
C 00A2 2D43 2
C 00A4 414D 0
C 00A6 004E 1
C 00A8 0000 0
C 00AA 0000 3
C 00AC 4600 0
C 00AE 414C 1
C 00B0 4853 0
C 00B2 4D31 2
C 00B4 565F 0
E
X 1 1 1 2 2D
S C5
C 00A0 4554 0
C 00A2 5254 1
C 00A4 5349 0
C 00A6 0000 4
C 00A8 0000 0
C 00AA 0000 1
C 00AC 0000 0
E
X 0 0 0 3 2B

// ==== gba_cart_loader.f ====
+incdir+src
src/gba_loader_pkg.sv
src/dl_stream_classifier.sv
src/bios_word_packer.sv
src/flash_tag_scanner.sv
src/cart_quirk_matcher.sv
src/rom_write_port.sv
src/gba_cart_loader.sv
testbench/tb_gba_cart_loader.sv

// ==== Makefile ====
# Verilator simulation of the GBA cartridge loader

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f gba_cart_loader.f --top-module tb_gba_cart_loader -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_gba_cart_loader.sv ====
// Testbench for the GBA cartridge loader
// Replays host commands from the stimulus file, models the ROM memory
// acknowledge and checks BIOS writes, ROM writes and cartridge flags

`include "gba_loader_config.svh"

module tb_gba_cart_loader;

	typedef logic [4:0][31:0] args_t;          // Up to five hex fields per line

	localparam string STIM_FILE = "testbench/cart_stimulus.txt";

	logic                                clk_sys, reset, dl_active, dl_wr, rom_ack;
	logic [`GBA_INDEX_W-1:0]             dl_index;
	gba_loader_pkg::host_addr_t          dl_addr;
	gba_loader_pkg::host_word_t          dl_data, rom_data;
	logic                                dl_wait, rom_wr, bios_wr;
	logic                                flash_1m, sram_quirk, remap_quirk;
	gba_loader_pkg::rom_addr_t           rom_addr;
	gba_loader_pkg::bios_addr_t          bios_wraddr;
	gba_loader_pkg::dword_t              bios_wrdata;
	logic [`GBA_CART_TYPE_W-1:0]         cart_type;
	gba_loader_pkg::pak_addr_t           max_pak_addr;

	logic [7:0]                          cmd_q [$];     // Command letters
	args_t                               arg_q [$];
	gba_loader_pkg::bios_addr_t          exp_baddr [$]; // Predicted BIOS writes
	gba_loader_pkg::dword_t              exp_bdata [$];
	gba_loader_pkg::rom_addr_t           exp_raddr [$]; // Predicted ROM writes
	gba_loader_pkg::host_word_t          exp_rdata [$];
	int                                  exp_delay [$]; // Ack delay per ROM write
	gba_loader_pkg::host_word_t          bios_lo;       // Pending low halfword
	gba_loader_pkg::host_addr_t          last_cart_addr;
	logic [7:0]                          cart_index;
	logic                                in_cart = 1'b0;
	logic                                loaded = 1'b0;
	logic [31:0]                         lcg_state = 32'hc9ad_0655;
	int                                  errors = 0, bios_seen = 0, rom_seen = 0;

	gba_cart_loader i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;        // Period 20
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ==========================================================================
	// Compare tasks for each kind of result
	// ==========================================================================
	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_type(input logic [`GBA_CART_TYPE_W-1:0] got, exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: cart_type is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_pak(input gba_loader_pkg::pak_addr_t got, exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: max_pak_addr is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_bios_write(input gba_loader_pkg::bios_addr_t ga, ea,
	                                input gba_loader_pkg::dword_t gd, ed);
		if (ga !== ea || gd !== ed) begin
			errors++;
			$display("CHECK FAILED at %0t: BIOS write %h:%h, expected %h:%h",
			         $time, ga, gd, ea, ed);
		end
	endtask

	task automatic check_rom_write(input gba_loader_pkg::rom_addr_t ga, ea,
	                               input gba_loader_pkg::host_word_t gd, ed);
		if (ga !== ea || gd !== ed) begin
			errors++;
			$display("CHECK FAILED at %0t: ROM write %h:%h, expected %h:%h",
			         $time, ga, gd, ea, ed);
		end
	endtask

	// ==========================================================================
	// Host commands
	// ==========================================================================
	task automatic bios_write(input gba_loader_pkg::host_addr_t addr,
	                          input gba_loader_pkg::host_word_t data);
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_index  <= '0;                       // Index 0 selects the BIOS
		dl_addr   <= addr;
		dl_data   <= data;
		dl_wr     <= 1'b1;                     // Back to back if the next line is B too
		if (!addr[1])
			bios_lo = data;
		else begin
			exp_baddr.push_back(addr[13:2]);
			exp_bdata.push_back({data, bios_lo});
		end
	endtask

	task automatic cart_begin(input logic [7:0] index);
		@(posedge clk_sys);
		dl_wr      <= 1'b0;
		dl_active  <= 1'b1;
		dl_index   <= index;
		cart_index = index;
		in_cart    = 1'b1;
		repeat (3) @(posedge clk_sys);         // Start pulse and its effects
	endtask

	task automatic cart_write(input gba_loader_pkg::host_addr_t addr,
	                          input gba_loader_pkg::host_word_t data, input int delay);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		exp_raddr.push_back(gba_loader_pkg::rom_addr_t'((32'(addr) + `GBA_ROM_START) >> 1));
		exp_rdata.push_back(data);
		exp_delay.push_back(delay);
		last_cart_addr = addr;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		@(negedge clk_sys);
		while (!dl_wait) @(negedge clk_sys);   // Host sees wait rise
		while (dl_wait) @(negedge clk_sys);    // and fall again
	endtask

	task automatic download_end();
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_sys);         // End pulse and the latch after it
		@(negedge clk_sys);
		if (in_cart) begin
			check_pak(max_pak_addr, gba_loader_pkg::pak_addr_t'(last_cart_addr >> 2));
			check_type(cart_type, cart_index[7:6]);
		end
		in_cart = 1'b0;
	endtask

	task automatic expect_flags(input args_t args);
		@(negedge clk_sys);
		check_flag("flash_1m", flash_1m, args[0][0]);
		check_flag("sram_quirk", sram_quirk, args[1][0]);
		check_flag("remap_quirk", remap_quirk, args[2][0]);
		check_type(cart_type, args[3][1:0]);
		check_pak(max_pak_addr, gba_loader_pkg::pak_addr_t'(args[4]));
	endtask

	// BIOS RAM monitor
	initial begin
		forever begin
			@(negedge clk_sys);
			if (bios_wr) begin
				bios_seen++;
				if (exp_baddr.size() == 0) begin
					errors++;
					$display("BIOS write at %0t that no halfword pair asked for", $time);
				end else
					check_bios_write(bios_wraddr, exp_baddr.pop_front(),
					                 bios_wrdata, exp_bdata.pop_front());
			end
		end
	end

	// ROM memory model answers each write after the listed delay
	initial begin
		int delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_wr) begin
				rom_seen++;
				delay = 1;
				check_flag("dl_wait with rom_wr", dl_wait, 1'b1);
				if (exp_raddr.size() == 0) begin
					errors++;
					$display("ROM write at %0t that no cartridge word asked for", $time);
				end else begin
					check_rom_write(rom_addr, exp_raddr.pop_front(),
					                rom_data, exp_rdata.pop_front());
					delay = exp_delay.pop_front();
				end
				if (delay == 0) begin
					lcg_state = lcg_next(lcg_state);
					delay = 1 + int'(lcg_state[31:16] % 16'd4);
				end
				repeat (delay - 1) begin
					@(negedge clk_sys);
					check_flag("dl_wait before rom_ack", dl_wait, 1'b1); // Host still held
				end
				@(posedge clk_sys);
				rom_ack <= 1'b1;
				@(posedge clk_sys);
				rom_ack <= 1'b0;
				@(negedge clk_sys);
				check_flag("dl_wait after rom_ack", dl_wait, 1'b0);
			end
		end
	end

	// Watchdog allows 200 cycles per stimulus line
	initial begin
		longint limit;
		wait (loaded);
		limit = 64'(cmd_q.size() + 8) * 200 * 20;
		#(limit);
		$display("Watchdog timeout: the run did not end within %0d time units", limit);
		$display("Test failed");
		$finish;
	end

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial begin
		int          fd, n, idx;
		string       line;
		logic [7:0]  cmd;
		logic [31:0] a0, a1, a2, a3, a4;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		dl_wr     = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file %s", STIM_FILE);
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				a0 = '0;
				a1 = '0;
				a2 = '0;
				a3 = '0;
				a4 = '0;
				n = $sscanf(line, "%c %h %h %h %h %h", cmd, a0, a1, a2, a3, a4);
				cmd_q.push_back(cmd);
				arg_q.push_back({a4, a3, a2, a1, a0});
			end
		end
		if (fd != 0)
			$fclose(fd);
		loaded = 1'b1;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (3) @(negedge clk_sys);         // Idle outputs after reset
		check_flag("bios_wr", bios_wr, 1'b0);
		check_flag("rom_wr", rom_wr, 1'b0);
		check_flag("dl_wait", dl_wait, 1'b0);
		check_flag("flash_1m", flash_1m, 1'b0);
		check_flag("sram_quirk", sram_quirk, 1'b0);
		check_flag("remap_quirk", remap_quirk, 1'b0);
		for (idx = 0; idx < cmd_q.size(); idx++) begin
			case (cmd_q[idx])
				"B": bios_write(arg_q[idx][0][`GBA_ADDR_W-1:0], arg_q[idx][1][15:0]);
				"S": cart_begin(arg_q[idx][0][7:0]);
				"C": cart_write(arg_q[idx][0][`GBA_ADDR_W-1:0], arg_q[idx][1][15:0],
				                int'(arg_q[idx][2]));
				"E": download_end();
				"X": expect_flags(arg_q[idx]);
				default: begin
					errors++;
					$display("Unknown stimulus command %c in entry %0d", cmd_q[idx], idx);
				end
			endcase
		end
		repeat (4) @(posedge clk_sys);
		if (exp_baddr.size() != 0 || exp_raddr.size() != 0) begin
			errors++;
			$display("%0d BIOS and %0d ROM writes never came out",
			         exp_baddr.size(), exp_raddr.size());
		end
		$display("Errors: %0d, BIOS writes: %0d, ROM writes: %0d, stimulus lines: %0d",
		         errors, bios_seen, rom_seen, cmd_q.size());
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== src/gba_cart_loader.sv ====
// GBA cartridge and BIOS loader, top level
// Stage one classifies the host download stream; stage two packs BIOS
// dwords, writes the cartridge to ROM memory and derives the save type
// and the quirk flags from the image

`include "gba_loader_config.svh"

module gba_cart_loader (
	input  logic                        clk_sys,
	input  logic                        reset,
	// Host download stream
	input  logic                        dl_active,
	input  logic [`GBA_INDEX_W-1:0]     dl_index,
	input  gba_loader_pkg::host_addr_t  dl_addr,
	input  gba_loader_pkg::host_word_t  dl_data,
	input  logic                        dl_wr,
	output logic                        dl_wait,
	// External ROM memory
	output logic                        rom_wr,
	output gba_loader_pkg::rom_addr_t   rom_addr,
	output gba_loader_pkg::host_word_t  rom_data,
	input  logic                        rom_ack,
	// BIOS RAM
	output logic                        bios_wr,
	output gba_loader_pkg::bios_addr_t  bios_wraddr,
	output gba_loader_pkg::dword_t      bios_wrdata,
	// Cartridge properties for the core
	output logic                        flash_1m,
	output logic                        sram_quirk,
	output logic                        remap_quirk,
	output logic [`GBA_CART_TYPE_W-1:0] cart_type,
	output gba_loader_pkg::pak_addr_t   max_pak_addr
);

	// Stage one outputs, fan out to all consumers
	gba_loader_pkg::dl_kind_e   s1_kind;
	gba_loader_pkg::host_addr_t s1_addr;
	gba_loader_pkg::host_word_t s1_data;
	logic                       s1_wr;
	logic [`GBA_INDEX_W-1:0]    s1_index;
	logic                       cart_start;
	logic                       cart_end;

	dl_stream_classifier i_classifier (
		.clk_sys, .reset,
		.dl_active, .dl_index, .dl_addr, .dl_data, .dl_wr,
		.s1_kind, .s1_addr, .s1_data, .s1_wr, .cart_start, .cart_end, .s1_index
	);

	bios_word_packer i_bios_packer (
		.clk_sys, .reset,
		.s1_kind, .s1_addr, .s1_data, .s1_wr,
		.bios_wr, .bios_wraddr, .bios_wrdata
	);

	flash_tag_scanner i_flash_scan (
		.clk_sys, .reset,
		.s1_kind, .s1_data, .s1_wr, .cart_start,
		.flash_1m
	);

	cart_quirk_matcher i_quirks (
		.clk_sys, .reset,
		.s1_kind, .s1_addr, .s1_data, .s1_wr, .cart_start,
		.sram_quirk, .remap_quirk
	);

	rom_write_port i_rom_port (
		.clk_sys, .reset,
		.s1_kind, .s1_addr, .s1_data, .s1_wr, .s1_index, .cart_start, .cart_end,
		.rom_ack, .rom_wr, .rom_addr, .rom_data, .dl_wait, .cart_type, .max_pak_addr
	);

endmodule

// ==== src/rom_write_port.sv ====
// Cartridge ROM write port
// Forwards each cartridge word to external memory above the ROM base,
// holds the host with dl_wait until the memory acknowledges, and keeps
// the cartridge type and the highest pak address

`include "gba_loader_config.svh"

module rom_write_port (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::dl_kind_e   s1_kind,
	input  gba_loader_pkg::host_addr_t s1_addr,
	input  gba_loader_pkg::host_word_t s1_data,
	input  logic                       s1_wr,
	input  logic [`GBA_INDEX_W-1:0]    s1_index,
	input  logic                       cart_start,
	input  logic                       cart_end,
	input  logic                       rom_ack,
	output logic                       rom_wr,
	output gba_loader_pkg::rom_addr_t  rom_addr,
	output gba_loader_pkg::host_word_t rom_data,
	output logic                       dl_wait,
	output logic [`GBA_CART_TYPE_W-1:0] cart_type,
	output gba_loader_pkg::pak_addr_t  max_pak_addr
);

	localparam gba_loader_pkg::host_addr_t ROM_BASE = `GBA_ADDR_W'(`GBA_ROM_START);

	typedef enum logic {
		WR_IDLE,                               // Ready for the next word
		WR_BUSY                                // Write out, waiting on rom_ack
	} wr_state_e;

	wr_state_e                  state;
	logic                       issue;         // Cartridge word accepted this cycle
	gba_loader_pkg::host_addr_t last_addr;

	assign issue   = s1_wr && (s1_kind == gba_loader_pkg::DL_CART) && (state == WR_IDLE);
	assign dl_wait = (state == WR_BUSY);       // Rises together with rom_wr

	// ==========================================================================
	// Write handshake FSM
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= WR_IDLE;
			rom_wr       <= 1'b0;
			cart_type    <= '0;
			max_pak_addr <= '0;
		end else begin
			rom_wr <= issue;
			case (state)
				WR_IDLE: if (issue)   state <= WR_BUSY;
				WR_BUSY: if (rom_ack) state <= WR_IDLE; // Host released next cycle
				default:              state <= WR_IDLE;
			endcase
			if (cart_start)
				cart_type <= s1_index[`GBA_INDEX_W-1 -: `GBA_CART_TYPE_W];
			if (cart_end)
				max_pak_addr <= last_addr[`GBA_ADDR_W-1:2];
		end
	end

	// Address is (byte address + base) / 2
	always_ff @(posedge clk_sys) begin
		if (issue) begin
			rom_addr  <= s1_addr[`GBA_ADDR_W-1:1] + ROM_BASE[`GBA_ADDR_W-1:1];
			rom_data  <= s1_data;
			last_addr <= s1_addr;
		end
	end

endmodule

// ==== src/cart_quirk_matcher.sv ====
// Cartridge quirk matcher
// Captures the 12-byte game title of the cartridge header and checks it
// against the titles that need SRAM disabled or the NES-classic remap

`include "gba_loader_config.svh"

module cart_quirk_matcher (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::dl_kind_e   s1_kind,
	input  gba_loader_pkg::host_addr_t s1_addr,
	input  gba_loader_pkg::host_word_t s1_data,
	input  logic                       s1_wr,
	input  logic                       cart_start,
	output logic                       sram_quirk,
	output logic                       remap_quirk
);

	localparam int TITLE_W   = `GBA_TITLE_LEN * 8;
	localparam int SRAM_ONLY = 8;              // First group, SRAM quirk alone
	localparam int N_TITLES  = 20;

	// ==========================================================================
	// Title table, zero padded on the right
	// ==========================================================================
	localparam logic [TITLE_W-1:0] QUIRK_TITLE [N_TITLES] = '{
		{"ROCKY BOXING"},                       // Rocky, US
		{"ROCKY", 56'h0},                       // Rocky, EU
		{"DBZ LGCYGOKU"},
		{"DRAGONBALL Z"},
		{"DBZ TAIKETSU"},
		{"DRAGON BALLZ"},
		{"TOPGUN CZ", 24'h0},
		{"IRIDIONII", 24'h0},
		{"BOMBER MAN", 16'h0},                  // NES classics from here on
		{"CASTLEVANIA", 8'h0},
		{"DONKEY KONG", 8'h0},
		{"DR. MARIO", 24'h0},
		{"EXCITEBIKE", 16'h0},
		{"ICE CLIMBER", 8'h0},
		{"NES METROID", 8'h0},
		{"PAC-MAN", 40'h0},
		{"SUPER MARIO", 8'h0},
		{"ZELDA 1", 40'h0},
		{"XEVIOUS", 40'h0},
		{"NES ZELDA 2", 8'h0}
	};

	logic [TITLE_W-1:0] cart_id;               // First title byte at the top
	logic               cart_wr;
	logic               in_title_blk;          // Write falls in block 0xA0..0xAF
	logic [6:0]         title_lsb;             // Bit slot of the incoming pair
	logic               sram_hit;
	logic               remap_hit;

	assign cart_wr      = s1_wr && (s1_kind == gba_loader_pkg::DL_CART);
	assign in_title_blk = (s1_addr[`GBA_ADDR_W-1:4] == (`GBA_ADDR_W-4)'(`GBA_TITLE_ADDR));
	assign title_lsb    = 7'(TITLE_W - 16) - {s1_addr[3:0], 3'b000};

	// Table lookup, NES group sets both flags
	always_comb begin
		sram_hit  = 1'b0;
		remap_hit = 1'b0;
		for (int i = 0; i < N_TITLES; i++) begin
			if (cart_id == QUIRK_TITLE[i]) begin
				sram_hit = 1'b1;
				if (i >= SRAM_ONLY)
					remap_hit = 1'b1;
			end
		end
	end

	// Title capture, byte order swapped to keep the string readable
	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title_blk && (s1_addr[3:0] < 4'(`GBA_TITLE_LEN)))
			cart_id[title_lsb +: 16] <= {s1_data[7:0], s1_data[15:8]};
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start) begin
			sram_quirk  <= 1'b0;
			remap_quirk <= 1'b0;
		end else if (cart_wr && in_title_blk && (s1_addr[3:0] == 4'(`GBA_TITLE_LEN))) begin
			if (sram_hit)
				sram_quirk <= 1'b1;            // Title is complete once 0xAC arrives
			if (remap_hit)
				remap_quirk <= 1'b1;
		end
	end

endmodule

// ==== src/flash_tag_scanner.sv ====
// FLASH1M_V tag scanner
// Watches the cartridge image as a byte stream and flags the 1 Mbit
// flash save type when the tag shows up at either byte alignment

`include "gba_loader_config.svh"

module flash_tag_scanner (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::dl_kind_e   s1_kind,
	input  gba_loader_pkg::host_word_t s1_data,
	input  logic                       s1_wr,
	input  logic                       cart_start,
	output logic                       flash_1m
);

	localparam logic [`GBA_TAG_LEN*8-1:0] FLASH_TAG = "FLASH1M_V";

	logic [`GBA_TAG_HIST_W-1:0] hist;          // Last bytes, newest in the low byte
	logic [`GBA_TAG_HIST_W-1:0] hist_base;     // History as seen by this write
	logic                       cart_wr;
	logic                       hit_lo;        // Tag ends at the low byte
	logic                       hit_hi;        // Tag ends at the high byte

	assign cart_wr   = s1_wr && (s1_kind == gba_loader_pkg::DL_CART);
	assign hist_base = cart_start ? '0 : hist; // New image starts with an empty window

	// Low byte comes first in the stream
	assign hit_lo = ({hist_base, s1_data[7:0]} == FLASH_TAG);
	assign hit_hi = ({hist_base[`GBA_TAG_HIST_W-9:0], s1_data[7:0], s1_data[15:8]}
	                 == FLASH_TAG);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m <= 1'b0;
		end else begin
			if (cart_start)
				flash_1m <= 1'b0;
			if (cart_wr && (hit_lo || hit_hi))
				flash_1m <= 1'b1;              // Sticky until the next image
		end
	end

	// Shift two bytes per cartridge word
	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			hist <= {hist_base[`GBA_TAG_HIST_W-17:0], s1_data[7:0], s1_data[15:8]};
		else if (cart_start)
			hist <= '0;
	end

endmodule

// ==== src/bios_word_packer.sv ====
// BIOS word packer
// Joins the two halfwords of each BIOS dword and writes them to BIOS RAM
// as one 32-bit write, at the word address of the pair

`include "gba_loader_config.svh"

module bios_word_packer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  gba_loader_pkg::dl_kind_e   s1_kind,
	input  gba_loader_pkg::host_addr_t s1_addr,
	input  gba_loader_pkg::host_word_t s1_data,
	input  logic                       s1_wr,
	output logic                       bios_wr,
	output gba_loader_pkg::bios_addr_t bios_wraddr,
	output gba_loader_pkg::dword_t     bios_wrdata
);

	logic bios_cycle;                          // BIOS halfword present this cycle

	assign bios_cycle = s1_wr && (s1_kind == gba_loader_pkg::DL_BIOS);

	// Write strobe, one pulse per completed dword
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_cycle & s1_addr[1]; // Upper half completes the pair
	end

	// Data assembly, low half first
	always_ff @(posedge clk_sys) begin
		if (bios_cycle) begin
			if (!s1_addr[1]) begin
				bios_wrdata[`GBA_DATA_W-1:0] <= s1_data;
			end else begin
				bios_wrdata[`GBA_DWORD_W-1:`GBA_DATA_W] <= s1_data;
				bios_wraddr <= s1_addr[`GBA_BIOS_AW+1:2]; // Byte address to word
			end
		end
	end

endmodule

// ==== src/dl_stream_classifier.sv ====
// Download stream classifier, first pipeline stage
// Registers the host stream, tags every word with its download kind
// and marks the first and last cycle of a cartridge download

`include "gba_loader_config.svh"

module dl_stream_classifier (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active,
	input  logic [`GBA_INDEX_W-1:0]    dl_index,
	input  gba_loader_pkg::host_addr_t dl_addr,
	input  gba_loader_pkg::host_word_t dl_data,
	input  logic                       dl_wr,
	output gba_loader_pkg::dl_kind_e   s1_kind,
	output gba_loader_pkg::host_addr_t s1_addr,
	output gba_loader_pkg::host_word_t s1_data,
	output logic                       s1_wr,
	output logic                       cart_start,
	output logic                       cart_end,
	output logic [`GBA_INDEX_W-1:0]    s1_index
);

	gba_loader_pkg::dl_kind_e kind_now;        // Kind of the current host cycle
	logic                     cart_now;
	logic                     cart_prev;       // Registered kind was cartridge

	// Nothing is downloading while dl_active is low
	assign kind_now  = dl_active ? gba_loader_pkg::kind_of_index(dl_index)
	                             : gba_loader_pkg::DL_NONE;
	assign cart_now  = (kind_now == gba_loader_pkg::DL_CART);
	assign cart_prev = (s1_kind == gba_loader_pkg::DL_CART);

	// Control side of the stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_kind    <= gba_loader_pkg::DL_NONE;
			s1_wr      <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			s1_kind    <= kind_now;
			s1_wr      <= dl_wr & dl_active;     // Stray strobes outside a download dropped
			cart_start <= cart_now & ~cart_prev; // Lines up with first cartridge cycle
			cart_end   <= ~cart_now & cart_prev; // First cycle after the cartridge
		end
	end

	// Payload follows the host one cycle later
	always_ff @(posedge clk_sys) begin
		s1_addr  <= dl_addr;
		s1_data  <= dl_data;
		s1_index <= dl_index;
	end

endmodule

// ==== src/gba_loader_pkg.sv ====
// GBA loader shared types
// Download kinds, the width types of the host, BIOS and ROM sides and
// the index decode used by the stream classifier

`include "gba_loader_config.svh"

package gba_loader_pkg;

	// Kind of the running download
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,                         // Idle or code download
		DL_BIOS = 2'd1,
		DL_CART = 2'd2
	} dl_kind_e;

	typedef logic [`GBA_ADDR_W-1:0]  host_addr_t;   // Byte address from host
	typedef logic [`GBA_DATA_W-1:0]  host_word_t;
	typedef logic [`GBA_BIOS_AW-1:0] bios_addr_t;
	typedef logic [`GBA_DWORD_W-1:0] dword_t;
	typedef logic [`GBA_PAK_AW-1:0]  pak_addr_t;    // 32-bit word address
	typedef logic [`GBA_ROM_AW-1:0]  rom_addr_t;    // Halfword address

	// Index 0 is the BIOS, all ones the cheat file, the rest cartridges
	function automatic dl_kind_e kind_of_index(input logic [`GBA_INDEX_W-1:0] index);
		if (index == '0)
			return DL_BIOS;
		else if (&index)
			return DL_NONE;                     // Code path is not part of this core
		return DL_CART;
	endfunction

endpackage

// ==== src/gba_loader_config.svh ====
// GBA cartridge loader configuration
// Widths, the ROM offset in external memory and the header positions
// used by the loader stages
`ifndef GBA_LOADER_CONFIG_SVH
`define GBA_LOADER_CONFIG_SVH

// ==========================================================================
// Bus widths
// ==========================================================================
`define GBA_ADDR_W      27                      // Host byte address
`define GBA_DATA_W      16                      // Host word
`define GBA_DWORD_W     32                      // BIOS RAM word
`define GBA_BIOS_AW     12                      // BIOS RAM word address
`define GBA_PAK_AW      25                      // Pak address in 32-bit words
`define GBA_ROM_AW      26                      // ROM halfword address
`define GBA_INDEX_W     8                       // Download index
`define GBA_CART_TYPE_W 2                       // Type bits, top of the index

// ==========================================================================
// Memory map and header layout
// ==========================================================================
`define GBA_ROM_START   786432                  // ROM base byte offset
`define GBA_TITLE_ADDR  10                      // 16-byte block of the title, 0xA0
`define GBA_TITLE_LEN   12                      // Title bytes A0..AB
`define GBA_TAG_LEN     9                       // Length of the FLASH1M_V tag
`define GBA_TAG_HIST_W  ((`GBA_TAG_LEN - 1) * 8) // Byte history before the tag end

`endif
